//--- Makefile
# Verilator build and run for the aluCore testbench

SIM = obj_dir/ValuCoreTb

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when the file list or a source changes
$(SIM): aluCore.f $(wildcard design/*.sv design/*.svh tb/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f aluCore.f --top-module aluCoreTb -o ValuCoreTb

# Exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir

//--- aluCore.f
+incdir+design
design/aluCorePkg.sv
design/aluCoreRegs.sv
design/aluDecode.sv
design/aluExecute.sv
design/aluResult.sv
design/aluCore.sv
tb/tbClock.sv
tb/aluCore_chk.sv
tb/aluCoreTb.sv

//--- design/aluCore.sv
`default_nettype none
`timescale 1ns/1ps

`include "aluCore_consts.svh"

module aluCore (
    input wire clk,
    input wire reset,
    input wire [`ALU_ADDR_W-1:0] awaddr,
    input wire awvalid,
    output logic awready,
    input wire [`ALU_DATA_W-1:0] wdata,
    input wire [`ALU_DATA_W/8-1:0] wstrb,
    input wire wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input wire bready,
    input wire [`ALU_ADDR_W-1:0] araddr,
    input wire arvalid,
    output logic arready,
    output aluCorePkg::data_t rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input wire rready
);

    logic issue;
    aluCorePkg::instrWord_t instr;
    aluCorePkg::regIdx_t rs1Idx, rs2Idx;
    aluCorePkg::data_t rs1Data, rs2Data;

    // Decode to execute
    logic decValid;
    aluCorePkg::aluOp_t decOp;
    aluCorePkg::regIdx_t decRd;
    aluCorePkg::data_t decA, decB, decImm, decPc;

    // Execute to result
    logic exValid;
    aluCorePkg::aluOp_t exOp;
    aluCorePkg::regIdx_t exRd;
    aluCorePkg::data_t exResult;

    // Writeback and PC
    logic wbEn, done, pcLoad;
    aluCorePkg::regIdx_t wbIdx;
    aluCorePkg::data_t wbData, pc, pcLoadData;
    logic [15:0] count;

    aluCoreRegs u_regs (
        .clk(clk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .issue(issue), .instr(instr),
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData), .done(done),
        .pc(pc), .count(count), .pcLoad(pcLoad), .pcLoadData(pcLoadData)
    );

    aluDecode u_decode (
        .clk(clk), .reset(reset), .issue(issue), .instr(instr),
        .rs1Idx(rs1Idx), .rs2Idx(rs2Idx), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .pc(pc), .decValid(decValid), .decOp(decOp), .decRd(decRd),
        .decA(decA), .decB(decB), .decImm(decImm), .decPc(decPc)
    );

    aluExecute u_execute (
        .clk(clk), .reset(reset),
        .decValid(decValid), .decOp(decOp), .decRd(decRd),
        .decA(decA), .decB(decB), .decImm(decImm), .decPc(decPc),
        .exValid(exValid), .exOp(exOp), .exRd(exRd), .exResult(exResult)
    );

    aluResult u_result (
        .clk(clk), .reset(reset),
        .exValid(exValid), .exOp(exOp), .exRd(exRd), .exResult(exResult),
        .wbEn(wbEn), .wbIdx(wbIdx), .wbData(wbData), .done(done),
        .pc(pc), .count(count), .pcLoad(pcLoad), .pcLoadData(pcLoadData)
    );

endmodule

`default_nettype wire

//--- design/aluCorePkg.sv
`default_nettype none

`include "aluCore_consts.svh"

package aluCorePkg;

    typedef logic [`ALU_DATA_W-1:0] data_t;
    typedef logic [$clog2(`ALU_NREGS)-1:0] regIdx_t;

    // Opcode field of the instruction word
    typedef enum logic [4:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        MUL  = 5'd2,
        DIV  = 5'd3,
        ABS  = 5'd4,
        SLT  = 5'd5,
        SEQ  = 5'd6,
        SNEZ = 5'd7,
        MIN  = 5'd8,
        SLL  = 5'd9,
        ADDI = 5'd10,
        MULI = 5'd11,
        DIVI = 5'd12,
        SLLI = 5'd13,
        BEQZ = 5'd14,
        JAL  = 5'd15
    } aluOp_t;

    typedef struct packed {
        aluOp_t opcode;
        regIdx_t rd;
        regIdx_t rs1;
        regIdx_t rs2;
        logic [17:0] unused;
    } rType_t;

    typedef struct packed {
        aluOp_t opcode;
        regIdx_t rd;
        regIdx_t rs1;
        logic signed [20:0] imm; // Sign extended in decode
    } iType_t;

    // One instruction word, two views
    typedef union packed {
        rType_t rType;
        iType_t iType;
    } instrWord_t;

endpackage

`default_nettype wire

//--- design/aluCoreRegs.sv
`default_nettype none
`timescale 1ns/1ps

`include "aluCore_consts.svh"

module aluCoreRegs (
    input wire clk,
    input wire reset,
    // AXI4-Lite slave
    input wire [`ALU_ADDR_W-1:0] awaddr,
    input wire awvalid,
    output logic awready,
    input wire [`ALU_DATA_W-1:0] wdata,
    input wire [`ALU_DATA_W/8-1:0] wstrb,
    input wire wvalid,
    output logic wready,
    output logic [1:0] bresp,
    output logic bvalid,
    input wire bready,
    input wire [`ALU_ADDR_W-1:0] araddr,
    input wire arvalid,
    output logic arready,
    output aluCorePkg::data_t rdata,
    output logic [1:0] rresp,
    output logic rvalid,
    input wire rready,
    // Core side
    output logic issue,
    output aluCorePkg::instrWord_t instr,
    input aluCorePkg::regIdx_t rs1Idx,
    input aluCorePkg::regIdx_t rs2Idx,
    output aluCorePkg::data_t rs1Data,
    output aluCorePkg::data_t rs2Data,
    input wire wbEn,
    input aluCorePkg::regIdx_t wbIdx,
    input aluCorePkg::data_t wbData,
    input wire done,
    input aluCorePkg::data_t pc,
    input wire [15:0] count,
    output logic pcLoad,
    output aluCorePkg::data_t pcLoadData
);

    aluCorePkg::data_t regFile [1:`ALU_NREGS-1]; // Register 0 is not stored
    logic busy;
    logic wrAccept;
    logic rdAccept;
    logic awIsReg, awIsPc, awIsInstr, awIsStatus, awMapped;
    logic arIsReg, arMapped;
    aluCorePkg::regIdx_t awIdx, arIdx;
    aluCorePkg::data_t statusWord;
    aluCorePkg::data_t rdMux;

    // Write address decode
    assign awIsReg = (awaddr < `ALU_NREGS * 4) && (awaddr[1:0] == 2'b00);
    assign awIsPc = (awaddr == `ALU_PC_ADDR);
    assign awIsInstr = (awaddr == `ALU_INSTR_ADDR);
    assign awIsStatus = (awaddr == `ALU_STATUS_ADDR);
    assign awMapped = awIsReg | awIsPc | awIsInstr | awIsStatus;
    assign awIdx = aluCorePkg::regIdx_t'(awaddr[4:2]);

    // Address and data taken together; instruction writes stall while busy
    assign wrAccept = awvalid && wvalid && !bvalid && !(awIsInstr && busy);
    assign awready = wrAccept;
    assign wready = wrAccept;

    assign issue = wrAccept && awIsInstr;
    assign instr = aluCorePkg::instrWord_t'(wdata);
    assign pcLoad = wrAccept && awIsPc;
    assign pcLoadData = wdata;

    // Operand reads, same cycle
    assign rs1Data = (rs1Idx == '0) ? '0 : regFile[rs1Idx];
    assign rs2Data = (rs2Idx == '0) ? '0 : regFile[rs2Idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < `ALU_NREGS; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            if (wrAccept && awIsReg && awIdx != '0) begin
                regFile[awIdx] <= wdata;
            end
            // Later assignment, so writeback wins a collision
            if (wbEn && wbIdx != '0) begin
                regFile[wbIdx] <= wbData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (issue) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;
        end
    end

    // Write response
    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid <= 1'b0;
            bresp <= `ALU_RESP_OKAY;
        end else if (wrAccept) begin
            bvalid <= 1'b1;
            bresp <= awMapped ? `ALU_RESP_OKAY : `ALU_RESP_SLVERR;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    // Read side
    assign arIsReg = (araddr < `ALU_NREGS * 4) && (araddr[1:0] == 2'b00);
    assign arIdx = aluCorePkg::regIdx_t'(araddr[4:2]);
    assign statusWord = {count, 15'd0, busy};
    assign arMapped = arIsReg || araddr == `ALU_PC_ADDR ||
                      araddr == `ALU_INSTR_ADDR || araddr == `ALU_STATUS_ADDR;

    always_comb begin
        rdMux = '0; // INSTR and unmapped read zero
        if (arIsReg) begin
            rdMux = (arIdx == '0) ? '0 : regFile[arIdx];
        end else if (araddr == `ALU_PC_ADDR) begin
            rdMux = pc;
        end else if (araddr == `ALU_STATUS_ADDR) begin
            rdMux = statusWord;
        end
    end

    assign arready = !rvalid;
    assign rdAccept = arvalid && arready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
            rresp <= `ALU_RESP_OKAY;
        end else if (rdAccept) begin
            rvalid <= 1'b1;
            rresp <= arMapped ? `ALU_RESP_OKAY : `ALU_RESP_SLVERR;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rdAccept) begin
            rdata <= rdMux;
        end
    end

endmodule

`default_nettype wire

//--- design/aluCore_consts.svh
`ifndef ALU_CORE_CONSTS_SVH
`define ALU_CORE_CONSTS_SVH

// Datapath and register file size
`define ALU_DATA_W 32
`define ALU_NREGS 8

// AXI4-Lite address width
`define ALU_ADDR_W 32

// Register map, byte offsets
// GPRs sit at 0x00..0x1C, one word each
`define ALU_PC_ADDR 32'h20
`define ALU_INSTR_ADDR 32'h24
`define ALU_STATUS_ADDR 32'h28

// AXI response codes
`define ALU_RESP_OKAY 2'b00
`define ALU_RESP_SLVERR 2'b10

`endif

//--- design/aluDecode.sv
`default_nettype none
`timescale 1ns/1ps

`include "aluCore_consts.svh"

module aluDecode (
    input wire clk,
    input wire reset,
    input wire issue,
    input aluCorePkg::instrWord_t instr,
    output aluCorePkg::regIdx_t rs1Idx,
    output aluCorePkg::regIdx_t rs2Idx,
    input aluCorePkg::data_t rs1Data,
    input aluCorePkg::data_t rs2Data,
    input aluCorePkg::data_t pc,
    output logic decValid,
    output aluCorePkg::aluOp_t decOp,
    output aluCorePkg::regIdx_t decRd,
    output aluCorePkg::data_t decA,
    output aluCorePkg::data_t decB,
    output aluCorePkg::data_t decImm,
    output aluCorePkg::data_t decPc
);

    logic isIType;
    aluCorePkg::data_t immExt;

    // Opcodes that carry an immediate
    always_comb begin
        case (instr.rType.opcode)
            aluCorePkg::ADDI,
            aluCorePkg::MULI,
            aluCorePkg::DIVI,
            aluCorePkg::SLLI,
            aluCorePkg::BEQZ,
            aluCorePkg::JAL: isIType = 1'b1;
            default: isIType = 1'b0;
        endcase
    end

    // rs1 sits in the same place in both views
    assign rs1Idx = instr.rType.rs1;
    assign rs2Idx = isIType ? '0 : instr.rType.rs2; // Register 0 reads zero

    assign immExt = isIType
        ? {{(`ALU_DATA_W-21){instr.iType.imm[20]}}, instr.iType.imm}
        : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            decValid <= 1'b0;
        end else begin
            decValid <= issue;
        end
    end

    // Operand latch, payload only
    always_ff @(posedge clk) begin
        if (issue) begin
            decOp <= instr.rType.opcode;
            decRd <= instr.rType.rd;
            decA <= rs1Data;
            decB <= rs2Data;
            decImm <= immExt;
            decPc <= pc;
        end
    end

endmodule

`default_nettype wire

//--- design/aluExecute.sv
`default_nettype none
`timescale 1ns/1ps

`include "aluCore_consts.svh"

module aluExecute (
    input wire clk,
    input wire reset,
    input wire decValid,
    input aluCorePkg::aluOp_t decOp,
    input aluCorePkg::regIdx_t decRd,
    input aluCorePkg::data_t decA,
    input aluCorePkg::data_t decB,
    input aluCorePkg::data_t decImm,
    input aluCorePkg::data_t decPc,
    output logic exValid,
    output aluCorePkg::aluOp_t exOp,
    output aluCorePkg::regIdx_t exRd,
    output aluCorePkg::data_t exResult
);

    aluCorePkg::data_t aluOut;

    always_comb begin
        case (decOp)
            aluCorePkg::ADD: aluOut = decA + decB;
            aluCorePkg::SUB: aluOut = decA - decB;
            aluCorePkg::MUL: aluOut = decA * decB; // Low word only
            aluCorePkg::DIV: aluOut = (decB == '0) ? '1 : decA / decB;
            aluCorePkg::ABS: aluOut = decA[`ALU_DATA_W-1] ? -decA : decA;
            aluCorePkg::SLT: aluOut = (decA < decB) ? 1 : 0; // Unsigned compare
            aluCorePkg::SEQ: aluOut = (decA == decB) ? 1 : 0;
            aluCorePkg::SNEZ: aluOut = (decA != '0) ? 1 : 0;
            aluCorePkg::MIN: aluOut = (decA < decB) ? decA : decB;
            aluCorePkg::SLL: aluOut = decA << decB[4:0];
            aluCorePkg::ADDI: aluOut = decA + decImm;
            aluCorePkg::MULI: aluOut = decA * decImm;
            aluCorePkg::DIVI: aluOut = (decImm == '0) ? '1 : decA / decImm;
            aluCorePkg::SLLI: aluOut = decA << decImm[4:0];
            // Flag only, no branch taken
            aluCorePkg::BEQZ: aluOut = (decA == '0) ? 1 : 0;
            aluCorePkg::JAL: aluOut = decPc + decImm; // Jump target
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exValid <= 1'b0;
        end else begin
            exValid <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (decValid) begin
            exOp <= decOp;
            exRd <= decRd;
            exResult <= aluOut;
        end
    end

endmodule

`default_nettype wire

//--- design/aluResult.sv
`default_nettype none
`timescale 1ns/1ps

`include "aluCore_consts.svh"

module aluResult (
    input wire clk,
    input wire reset,
    input wire exValid,
    input aluCorePkg::aluOp_t exOp,
    input aluCorePkg::regIdx_t exRd,
    input aluCorePkg::data_t exResult,
    output logic wbEn,
    output aluCorePkg::regIdx_t wbIdx,
    output aluCorePkg::data_t wbData,
    output logic done,
    output aluCorePkg::data_t pc,
    output logic [15:0] count,
    input wire pcLoad,
    input aluCorePkg::data_t pcLoadData
);

    always_ff @(posedge clk) begin
        if (reset) begin
            wbEn <= 1'b0;
            pc <= '0;
            count <= '0;
        end else begin
            wbEn <= exValid;
            if (exValid) begin
                pc <= (exOp == aluCorePkg::JAL) ? exResult : pc + 4;
                count <= count + 16'd1; // Wraps at 16 bits
            end else if (pcLoad) begin
                pc <= pcLoadData;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exValid) begin
            wbIdx <= exRd;
            wbData <= exResult;
        end
    end

    // Writeback is the last step, so it also releases busy
    assign done = wbEn;

endmodule

`default_nettype wire

//--- tb/aluCoreTb.sv
`default_nettype none
`timescale 1ns/1ps

`include "aluCore_consts.svh"

module aluCoreTb;

    localparam int MaxWait = 100; // Cycles per handshake, polls per idle wait
    localparam int NumRandom = 300;

    logic clk;
    logic reset;
    logic [`ALU_ADDR_W-1:0] awaddr;
    logic awvalid;
    logic awready;
    aluCorePkg::data_t wdata;
    logic [`ALU_DATA_W/8-1:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [`ALU_ADDR_W-1:0] araddr;
    logic arvalid;
    logic arready;
    aluCorePkg::data_t rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;

    // Reference model state
    aluCorePkg::data_t modelRegs [`ALU_NREGS];
    aluCorePkg::data_t modelPc;
    logic [15:0] modelCount;

    tbClock u_clk (.clk(clk));

    aluCore u_dut (
        .clk(clk), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
    );

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic compareData(input string what, input aluCorePkg::data_t got,
            input aluCorePkg::data_t exp);
        if (got !== exp) begin
            stopWithError($sformatf("MISMATCH at %0t: %s read %h, expected %h",
                $time, what, got, exp));
        end
    endtask

    task automatic compareResp(input string what, input logic [1:0] got,
            input logic [1:0] exp);
        if (got !== exp) begin
            stopWithError($sformatf("MISMATCH at %0t: %s response %b, expected %b",
                $time, what, got, exp));
        end
    endtask

    task automatic compareStatus(input aluCorePkg::data_t got, input logic expBusy,
            input logic [15:0] expCount, input bit countKnown);
        if (got[0] !== expBusy || got[15:1] !== 15'd0 ||
                (countKnown && got[31:16] !== expCount)) begin
            stopWithError($sformatf("MISMATCH at %0t: status %h, expected busy %b count %0d",
                $time, got, expBusy, expCount));
        end
    endtask

    // Called 1 ns after a rising edge; returns at the same phase
    task automatic axiWrite(input logic [`ALU_ADDR_W-1:0] addr, input aluCorePkg::data_t data,
            output logic [1:0] resp, output int stalled);
        int n;
        awaddr = addr;
        wdata = data;
        awvalid = 1'b1;
        wvalid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!(awready && wready)) begin
            if (awready !== wready) begin
                stopWithError("awready and wready differ while a write is pending");
            end
            n++;
            if (n > MaxWait) begin
                stopWithError("Timeout waiting for awready and wready");
            end
            @(negedge clk);
        end
        stalled = n;
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid = 1'b0;
        bready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!bvalid) begin
            n++;
            if (n > MaxWait) begin
                stopWithError("Timeout waiting for the write response");
            end
            @(negedge clk);
        end
        resp = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [`ALU_ADDR_W-1:0] addr, output aluCorePkg::data_t data,
            output logic [1:0] resp);
        int n;
        araddr = addr;
        arvalid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!arready) begin
            n++;
            if (n > MaxWait) begin
                stopWithError("Timeout waiting for arready");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        rready = 1'b1;
        n = 0;
        @(negedge clk);
        while (!rvalid) begin
            n++;
            if (n > MaxWait) begin
                stopWithError("Timeout waiting for the read data");
            end
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    function automatic logic [`ALU_ADDR_W-1:0] regAddr(input aluCorePkg::regIdx_t idx);
        return {27'd0, idx, 2'b00};
    endfunction

    task automatic hostWrite(input logic [`ALU_ADDR_W-1:0] addr, input aluCorePkg::data_t data);
        logic [1:0] resp;
        int stalled;
        axiWrite(addr, data, resp, stalled);
        compareResp("host write", resp, `ALU_RESP_OKAY);
    endtask

    task automatic checkRead(input string what, input logic [`ALU_ADDR_W-1:0] addr,
            input aluCorePkg::data_t exp);
        aluCorePkg::data_t data;
        logic [1:0] resp;
        axiRead(addr, data, resp);
        compareResp(what, resp, `ALU_RESP_OKAY);
        compareData(what, data, exp);
    endtask

    task automatic checkStatus(input logic expBusy, input bit countKnown);
        aluCorePkg::data_t st;
        logic [1:0] resp;
        axiRead(`ALU_STATUS_ADDR, st, resp);
        compareResp("status read", resp, `ALU_RESP_OKAY);
        compareStatus(st, expBusy, modelCount, countKnown);
    endtask

    task automatic setReg(input aluCorePkg::regIdx_t idx, input aluCorePkg::data_t val);
        hostWrite(regAddr(idx), val);
        if (idx != '0) begin
            modelRegs[idx] = val;
        end
    endtask

    task automatic setPc(input aluCorePkg::data_t val);
        hostWrite(`ALU_PC_ADDR, val);
        modelPc = val;
    endtask

    task automatic waitIdle();
        aluCorePkg::data_t st;
        logic [1:0] resp;
        int polls;
        polls = 0;
        axiRead(`ALU_STATUS_ADDR, st, resp);
        while (st[0]) begin
            polls++;
            if (polls > MaxWait) begin
                stopWithError("Timeout waiting for the busy flag to clear");
            end
            axiRead(`ALU_STATUS_ADDR, st, resp);
        end
    endtask

    function automatic bit isImmOp(input logic [4:0] opc);
        return opc inside {aluCorePkg::ADDI, aluCorePkg::MULI, aluCorePkg::DIVI,
                           aluCorePkg::SLLI, aluCorePkg::BEQZ, aluCorePkg::JAL};
    endfunction

    // Operation rules of the execution unit
    function automatic aluCorePkg::data_t modelExec(input logic [4:0] opc,
            input aluCorePkg::data_t a, input aluCorePkg::data_t b,
            input aluCorePkg::data_t imm, input aluCorePkg::data_t pcVal);
        case (opc)
            aluCorePkg::ADD: return a + b;
            aluCorePkg::SUB: return a - b;
            aluCorePkg::MUL: return a * b;
            aluCorePkg::DIV: return (b == 0) ? '1 : a / b;
            aluCorePkg::ABS: return a[31] ? 32'd0 - a : a;
            aluCorePkg::SLT: return {31'd0, a < b};
            aluCorePkg::SEQ: return {31'd0, a == b};
            aluCorePkg::SNEZ: return {31'd0, a != 0};
            aluCorePkg::MIN: return (a < b) ? a : b;
            aluCorePkg::SLL: return a << b[4:0];
            aluCorePkg::ADDI: return a + imm;
            aluCorePkg::MULI: return a * imm;
            aluCorePkg::DIVI: return (imm == 0) ? '1 : a / imm;
            aluCorePkg::SLLI: return a << imm[4:0];
            aluCorePkg::BEQZ: return {31'd0, a == 0};
            aluCorePkg::JAL: return pcVal + imm;
            default: return '0;
        endcase
    endfunction

    function automatic aluCorePkg::instrWord_t buildInstr(input logic [4:0] opc,
            input aluCorePkg::regIdx_t rd, input aluCorePkg::regIdx_t rs1,
            input aluCorePkg::regIdx_t rs2, input logic [20:0] imm);
        aluCorePkg::instrWord_t w;
        w.iType.opcode = aluCorePkg::aluOp_t'(opc);
        w.iType.rd = rd;
        w.iType.rs1 = rs1;
        w.iType.imm = imm; // R-type keeps these as random unused bits
        if (!isImmOp(opc)) begin
            w.rType.rs2 = rs2;
        end
        return w;
    endfunction

    function automatic aluCorePkg::data_t randOperand();
        case ($urandom_range(0, 5))
            0: return '0;
            1: return '1;
            2: return 32'h8000_0000;
            3: return $urandom_range(0, 70); // Shift amounts past 31 too
            default: return $urandom;
        endcase
    endfunction

    function automatic logic [20:0] randImm();
        case ($urandom_range(0, 3))
            0: return '0; // Zero divisor for DIVI
            1: return 21'($urandom_range(0, 70));
            default: return 21'($urandom);
        endcase
    endfunction

    // Model advances as soon as the write is accepted
    task automatic issueInstr(input logic [4:0] opc, input aluCorePkg::regIdx_t rd,
            input aluCorePkg::regIdx_t rs1, input aluCorePkg::regIdx_t rs2,
            input logic [20:0] imm, output int stalled);
        aluCorePkg::data_t res;
        logic [1:0] resp;
        res = modelExec(opc, modelRegs[rs1], modelRegs[rs2], {{11{imm[20]}}, imm}, modelPc);
        axiWrite(`ALU_INSTR_ADDR, buildInstr(opc, rd, rs1, rs2, imm), resp, stalled);
        compareResp("instruction write", resp, `ALU_RESP_OKAY);
        if (rd != '0) begin
            modelRegs[rd] = res;
        end
        modelPc = (opc == aluCorePkg::JAL) ? res : modelPc + 4;
        modelCount++;
    endtask

    task automatic runInstr(input logic [4:0] opc, input aluCorePkg::regIdx_t rd,
            input aluCorePkg::regIdx_t rs1, input aluCorePkg::regIdx_t rs2,
            input logic [20:0] imm);
        int stalled;
        issueInstr(opc, rd, rs1, rs2, imm, stalled);
        waitIdle();
        checkRead("destination register", regAddr(rd), modelRegs[rd]);
        checkRead("program counter", `ALU_PC_ADDR, modelPc);
    endtask

    task automatic checkAll();
        for (int i = 0; i < `ALU_NREGS; i++) begin
            checkRead("register", regAddr(aluCorePkg::regIdx_t'(i)), modelRegs[i]);
        end
        checkRead("program counter", `ALU_PC_ADDR, modelPc);
        checkStatus(1'b0, 1'b1);
    endtask

    initial begin
        logic [4:0] opc;
        logic [`ALU_ADDR_W-1:0] addr;
        aluCorePkg::data_t data;
        logic [1:0] resp;
        int stalled;
        void'($urandom(32'h66dd_b744));
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '1;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        for (int i = 0; i < `ALU_NREGS; i++) begin
            modelRegs[i] = '0;
        end
        modelPc = '0;
        modelCount = '0;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // Reset state, register 0 and STATUS writes
        checkAll();
        setReg('0, 32'hDEAD_BEEF);
        hostWrite(`ALU_STATUS_ADDR, '1);
        checkAll();

        // PC load and JAL
        setPc(32'h0000_0100);
        checkRead("program counter", `ALU_PC_ADDR, modelPc);
        runInstr(aluCorePkg::JAL, 3'd3, 3'd0, 3'd0, 21'h0_0040);
        runInstr(aluCorePkg::JAL, 3'd4, 3'd1, 3'd0, 21'h1F_FFF0); // Backward jump
        runInstr(aluCorePkg::ADDI, 3'd6, 3'd0, 3'd0, 21'h1F_FFFF);

        // Back to back, second depends on first
        issueInstr(aluCorePkg::ADDI, 3'd1, 3'd0, 3'd0, 21'd5, stalled);
        issueInstr(aluCorePkg::ADDI, 3'd2, 3'd1, 3'd0, 21'd3, stalled);
        if (stalled == 0) begin
            stopWithError("Second instruction write was accepted while busy");
        end
        waitIdle();
        checkAll();
        issueInstr(aluCorePkg::SUB, 3'd5, 3'd2, 3'd1, 21'd0, stalled);
        checkStatus(1'b1, 1'b0); // Still in flight
        waitIdle();
        checkAll();

        for (int n = 0; n < NumRandom; n++) begin
            if (n % 8 == 0) begin
                for (int k = 0; k < 3; k++) begin
                    setReg(aluCorePkg::regIdx_t'($urandom_range(1, 7)), randOperand());
                end
            end
            if (n % 50 == 49) begin
                setPc($urandom & 32'hFFFF_FFFC);
            end
            opc = ($urandom_range(0, 15) == 0) ? 5'($urandom_range(16, 31))
                                              : 5'($urandom_range(0, 15));
            runInstr(opc, aluCorePkg::regIdx_t'($urandom), aluCorePkg::regIdx_t'($urandom),
                aluCorePkg::regIdx_t'($urandom), randImm());
            if (n % 25 == 0) begin
                checkStatus(1'b0, 1'b1);
            end
        end
        checkAll();

        // Unmapped: past STATUS, or misaligned inside the register window
        for (int k = 0; k < 12; k++) begin
            addr = (k % 2 == 0) ? 32'h2C + 32'($urandom_range(0, 4095))
                                : {27'd0, 3'($urandom), 2'($urandom_range(1, 3))};
            axiWrite(addr, $urandom, resp, stalled);
            compareResp("unmapped write", resp, `ALU_RESP_SLVERR);
            axiRead(addr, data, resp);
            compareResp("unmapped read", resp, `ALU_RESP_SLVERR);
            compareData("unmapped read data", data, '0);
        end
        checkAll();

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/aluCore_chk.sv
`default_nettype none
`timescale 1ns/1ps

`include "aluCore_consts.svh"

module aluCore_chk (
    input wire clk,
    input wire reset,
    input wire [`ALU_ADDR_W-1:0] awaddr,
    input wire awvalid,
    input wire awready,
    input wire wvalid,
    input wire bvalid,
    input wire bready,
    input wire rvalid,
    input wire rready,
    input wire busy,
    input wire issue,
    input wire done
);

    logic instrAccept;

    assign instrAccept = awvalid && wvalid && awready && awaddr == `ALU_INSTR_ADDR;

    bvalidHeld: assert property (@(posedge clk) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rvalidHeld: assert property (@(posedge clk) disable iff (reset)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // Instruction write stalls for the whole busy window
    instrStall: assert property (@(posedge clk) disable iff (reset)
        issue |=> busy && !instrAccept ##1 busy && !instrAccept
            ##1 busy && !instrAccept ##1 !busy)
        else $error("busy window after issue wrong or instruction write accepted while busy");

    issueToDone: assert property (@(posedge clk) disable iff (reset)
        issue |-> ##3 done)
        else $error("done did not follow issue by three cycles");

endmodule

bind aluCore aluCore_chk u_chk (
    .clk(clk), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wvalid(wvalid),
    .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready),
    .busy(u_regs.busy), .issue(issue), .done(done)
);

`default_nettype wire

//--- tb/tbClock.sv
`default_nettype none
`timescale 1ns/1ps

module tbClock #(
    parameter int periodNs = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk; // Free running
    end

endmodule

`default_nettype wire
